//--- rtl/adc_calib_consts.svh
// acquisition path constants
// widths, channel count and calibration scaling shared by rtl and bench

`ifndef ADC_CALIB_CONSTS_SVH
`define ADC_CALIB_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// channel count
////////////////////////////////////////////////////////////////////////////

// number of identical acquisition channels
`define NUM_CH 2

////////////////////////////////////////////////////////////////////////////
// data widths
////////////////////////////////////////////////////////////////////////////

// raw ADC pin word, lowest two bits reserved
`define ADC_PIN_W 16
// signed sample after conversion
`define SMP_W 14

////////////////////////////////////////////////////////////////////////////
// calibration
////////////////////////////////////////////////////////////////////////////

// gain width and its fraction bits
`define CAL_MW 16
`define CAL_SHIFT 13
// gain value meaning 1.0
`define CAL_UNITY 8192
// field bit on top of the channel index
`define CAL_AW 2

`endif

//--- rtl/adc_calib_pkg.sv
// acquisition path types
// sample, calibration coefficient and register write word definitions

`include "adc_calib_consts.svh"

package adc_calib_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // stream and coefficient types
  ////////////////////////////////////////////////////////////////////////////

  // signed sample, two's complement
  typedef logic signed [`SMP_W-1:0] smp_t;

  // gain, fixed point with CAL_SHIFT fraction bits
  typedef logic signed [`CAL_MW-1:0] gain_t;

  // offset, same scale as the sample
  typedef logic signed [`SMP_W-1:0] offs_t;

  ////////////////////////////////////////////////////////////////////////////
  // register write word
  ////////////////////////////////////////////////////////////////////////////

  // offset view, spare bits above the value
  typedef struct packed {
    logic [`CAL_MW-`SMP_W-1:0] unused;
    offs_t                     offs;
  } offs_word_t;

  // one bus word, read as gain or as offset depending on the field bit
  typedef union packed {
    gain_t      gain;
    offs_word_t offs_w;
  } cal_word_u;

endpackage : adc_calib_pkg

//--- rtl/adc_frontend.sv
// ADC front end
// captures the pin words and turns the inverted offset binary code
// into signed samples with a continuous valid level

`include "adc_calib_consts.svh"

module adc_frontend
  import adc_calib_pkg::*;
(
  input  logic                                    adc_clk,
  input  logic                                    top_rst,
  // raw pin words, one per channel
  input  logic [`NUM_CH-1:0][`ADC_PIN_W-1:0]      adc_dat_i,
  // converted stream
  output smp_t [`NUM_CH-1:0]                      smp_o,
  output logic                                    smp_vld_o
);

  ////////////////////////////////////////////////////////////////////////////
  // sample capture
  ////////////////////////////////////////////////////////////////////////////

  // pin registers, no reset on the data path
  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < `NUM_CH; i++) begin
      // keep the msb, invert the rest
      // two reserved lsbs are dropped here
      smp_o[i] <= {adc_dat_i[i][`ADC_PIN_W-1], ~adc_dat_i[i][`ADC_PIN_W-2:2]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stream valid
  ////////////////////////////////////////////////////////////////////////////

  // converter runs freely, valid rises on the first clock after reset
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_vld_o <= 1'b0;
    end else begin
      smp_vld_o <= 1'b1;
    end
  end

endmodule : adc_frontend

//--- rtl/calib_regs.sv
// calibration register file
// per channel gain and offset, written by a plain strobe with the
// bus word decoded as gain or offset by the field bit

`include "adc_calib_consts.svh"

module calib_regs
  import adc_calib_pkg::*;
(
  input  logic                      adc_clk,
  input  logic                      top_rst,
  // write port
  input  logic                      cal_we_i,
  input  logic [`CAL_AW-1:0]        cal_addr_i,
  input  cal_word_u                 cal_dat_i,
  // coefficients to the channels
  output gain_t [`NUM_CH-1:0]       gain_o,
  output offs_t [`NUM_CH-1:0]       offs_o
);

  // address split, channel index below the field bit
  localparam int CH_W = `CAL_AW - 1;

  logic [CH_W-1:0] wr_ch;
  logic            wr_offs;

  // top bit selects the field
  assign wr_offs = cal_addr_i[`CAL_AW-1];
  assign wr_ch   = cal_addr_i[CH_W-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // register array
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      for (int i = 0; i < `NUM_CH; i++) begin
        // unity gain, no offset
        gain_o[i] <= gain_t'(`CAL_UNITY);
        offs_o[i] <= '0;
      end
    end else if (cal_we_i) begin
      for (int i = 0; i < `NUM_CH; i++) begin
        if (wr_ch == CH_W'(i)) begin
          if (wr_offs) begin
            // offset view, spare top bits ignored
            offs_o[i] <= cal_dat_i.offs_w.offs;
          end else begin
            // full word is the gain
            gain_o[i] <= cal_dat_i.gain;
          end
        end
      end
    end
  end

endmodule : calib_regs

//--- rtl/linear_calib.sv
// linear calibration for one channel
// stage 1 multiplies by the gain, stage 2 scales, adds the offset
// and saturates to the sample range

`include "adc_calib_consts.svh"

module linear_calib
  import adc_calib_pkg::*;
(
  input  logic  adc_clk,
  input  logic  top_rst,
  // input stream
  input  smp_t  smp_i,
  input  logic  vld_i,
  // coefficients
  input  gain_t gain_i,
  input  offs_t offs_i,
  // output stream, clip aligned with its sample
  output smp_t  smp_o,
  output logic  vld_o,
  output logic  clip_o
);

  // full product width
  localparam int PRD_W = `SMP_W + `CAL_MW;

  // sample range limits at product width
  localparam logic signed [PRD_W-1:0] SAT_MAX = (2 ** (`SMP_W - 1)) - 1;
  localparam logic signed [PRD_W-1:0] SAT_MIN = -(2 ** (`SMP_W - 1));

  // stage 1
  logic signed [PRD_W-1:0] prd_q;
  offs_t                   offs_q;
  logic                    vld_q;

  // stage 2 combinational
  logic signed [PRD_W-1:0] sum;
  smp_t                    sat_smp;
  logic                    sat_clip;

  ////////////////////////////////////////////////////////////////////////////
  // stage 1, multiply
  ////////////////////////////////////////////////////////////////////////////

  // offset sampled together with the gain
  always_ff @(posedge adc_clk) begin
    prd_q  <= smp_i * gain_i;
    offs_q <= offs_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 2, scale, offset, saturate
  ////////////////////////////////////////////////////////////////////////////

  // arithmetic shift floors toward minus infinity
  // full width sum cannot overflow
  always_comb begin
    sum      = (prd_q >>> `CAL_SHIFT) + offs_q;
    sat_clip = 1'b0;
    if (sum > SAT_MAX) begin
      sat_smp  = SAT_MAX[`SMP_W-1:0];
      sat_clip = 1'b1;
    end else if (sum < SAT_MIN) begin
      sat_smp  = SAT_MIN[`SMP_W-1:0];
      sat_clip = 1'b1;
    end else begin
      sat_smp  = sum[`SMP_W-1:0];
    end
  end

  always_ff @(posedge adc_clk) begin
    smp_o <= sat_smp;
  end

  // valid and clip follow the data through both stages
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      vld_q  <= 1'b0;
      vld_o  <= 1'b0;
      clip_o <= 1'b0;
    end else begin
      vld_q  <= vld_i;
      vld_o  <= vld_q;
      clip_o <= sat_clip;
    end
  end

endmodule : linear_calib

//--- rtl/dac_formatter.sv
// DAC output formatter
// turns calibrated samples into inverted DAC codes, registers them
// and keeps a sticky clip flag per channel

`include "adc_calib_consts.svh"

module dac_formatter
  import adc_calib_pkg::*;
(
  input  logic                              adc_clk,
  input  logic                              top_rst,
  // calibrated streams
  input  smp_t [`NUM_CH-1:0]                smp_i,
  input  logic [`NUM_CH-1:0]                vld_i,
  input  logic [`NUM_CH-1:0]                clip_i,
  // sticky flag clear
  input  logic                              clip_clr_i,
  // DAC side
  output logic [`NUM_CH-1:0][`SMP_W-1:0]    dac_dat_o,
  output logic                              dac_vld_o,
  output logic [`NUM_CH-1:0]                clip_o
);

  ////////////////////////////////////////////////////////////////////////////
  // DAC code
  ////////////////////////////////////////////////////////////////////////////

  // sign kept, magnitude bits inverted for the negative slope DAC
  always_ff @(posedge adc_clk) begin
    for (int i = 0; i < `NUM_CH; i++) begin
      dac_dat_o[i] <= {smp_i[i][`SMP_W-1], ~smp_i[i][`SMP_W-2:0]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // valid and clip flags
  ////////////////////////////////////////////////////////////////////////////

  // channels run in lockstep, channel 0 stands for all
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dac_vld_o <= 1'b0;
      clip_o    <= '0;
    end else begin
      dac_vld_o <= vld_i[0];
      for (int i = 0; i < `NUM_CH; i++) begin
        // clear beats a new clip in the same cycle
        if (clip_clr_i) begin
          clip_o[i] <= 1'b0;
        end else if (vld_i[i] && clip_i[i]) begin
          clip_o[i] <= 1'b1;
        end
      end
    end
  end

endmodule : dac_formatter

//--- rtl/adc_calib_top.sv
// acquisition path top level
// ADC capture, per channel linear calibration and DAC formatting,
// with a small register block for the calibration values

`include "adc_calib_consts.svh"

module adc_calib_top
  import adc_calib_pkg::*;
(
  input  logic                                adc_clk,
  input  logic                                top_rst,
  // ADC pins
  input  logic [`NUM_CH-1:0][`ADC_PIN_W-1:0]  adc_dat_i,
  // calibration write port
  input  logic                                cal_we_i,
  input  logic [`CAL_AW-1:0]                  cal_addr_i,
  input  logic [`CAL_MW-1:0]                  cal_dat_i,
  // clip status
  input  logic                                clip_clr_i,
  output logic [`NUM_CH-1:0]                  clip_o,
  // DAC side
  output logic [`NUM_CH-1:0][`SMP_W-1:0]      dac_dat_o,
  output logic                                dac_vld_o
);

  ////////////////////////////////////////////////////////////////////////////
  // local signals
  ////////////////////////////////////////////////////////////////////////////

  // converted ADC stream
  smp_t  [`NUM_CH-1:0] smp;
  logic                smp_vld;
  // coefficients
  gain_t [`NUM_CH-1:0] gain;
  offs_t [`NUM_CH-1:0] offs;
  // calibrated streams
  smp_t  [`NUM_CH-1:0] cal_smp;
  logic  [`NUM_CH-1:0] cal_vld;
  logic  [`NUM_CH-1:0] cal_clip;

  ////////////////////////////////////////////////////////////////////////////
  // front end and registers
  ////////////////////////////////////////////////////////////////////////////

  adc_frontend i_frontend (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .smp_o     (smp),
    .smp_vld_o (smp_vld)
  );

  // bus word goes straight into the union port
  calib_regs i_regs (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .cal_we_i   (cal_we_i),
    .cal_addr_i (cal_addr_i),
    .cal_dat_i  (cal_dat_i),
    .gain_o     (gain),
    .offs_o     (offs)
  );

  ////////////////////////////////////////////////////////////////////////////
  // channels
  ////////////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < `NUM_CH; i++) begin : for_ch
    linear_calib i_calib (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .smp_i   (smp[i]),
      .vld_i   (smp_vld),
      .gain_i  (gain[i]),
      .offs_i  (offs[i]),
      .smp_o   (cal_smp[i]),
      .vld_o   (cal_vld[i]),
      .clip_o  (cal_clip[i])
    );
  end : for_ch

  ////////////////////////////////////////////////////////////////////////////
  // DAC formatting
  ////////////////////////////////////////////////////////////////////////////

  dac_formatter i_formatter (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .smp_i      (cal_smp),
    .vld_i      (cal_vld),
    .clip_i     (cal_clip),
    .clip_clr_i (clip_clr_i),
    .dac_dat_o  (dac_dat_o),
    .dac_vld_o  (dac_vld_o),
    .clip_o     (clip_o)
  );

endmodule : adc_calib_top

//--- bench/tb_adc_calib.sv
// acquisition path testbench
// LFSR driven ADC words and calibration writes, checked against a
// cycle model of conversion, calibration, saturation and DAC coding

`include "adc_calib_consts.svh"

module tb_adc_calib;

  // offset field select on top of the channel index
  localparam int OFFS_SEL = 1 << (`CAL_AW - 1);
  localparam int SAT_MAX = (1 << (`SMP_W - 1)) - 1;
  localparam int SAT_MIN = -(1 << (`SMP_W - 1));

  logic                               adc_clk = 1'b0;
  logic                               top_rst;
  logic [`NUM_CH-1:0][`ADC_PIN_W-1:0] adc_dat_i;
  logic                               cal_we_i;
  logic [`CAL_AW-1:0]                 cal_addr_i;
  logic [`CAL_MW-1:0]                 cal_dat_i;
  logic                               clip_clr_i;
  logic [`NUM_CH-1:0]                 clip_o;
  logic [`NUM_CH-1:0][`SMP_W-1:0]     dac_dat_o;
  logic                               dac_vld_o;

  // model state
  int                             gain_m [`NUM_CH];
  int                             offs_m [`NUM_CH];
  logic [`NUM_CH-1:0]             clip_m;
  logic [`NUM_CH-1:0][`SMP_W-1:0] code_q [$];
  logic [`NUM_CH-1:0]             clip_q [$];
  logic [15:0]                    lfsr_state = 16'd70;
  int                             checks = 0;
  int                             errors = 0;
  int                             test_base = 0;

  adc_calib_top UUT (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .adc_dat_i  (adc_dat_i),
    .cal_we_i   (cal_we_i),
    .cal_addr_i (cal_addr_i),
    .cal_dat_i  (cal_dat_i),
    .clip_clr_i (clip_clr_i),
    .clip_o     (clip_o),
    .dac_dat_o  (dac_dat_o),
    .dac_vld_o  (dac_vld_o)
  );

  always #20 adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1, one step per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // pin word to expected DAC code and clip bit
  task automatic predict_sample(input logic [`ADC_PIN_W-1:0] pin, input int g, input int o,
                                output logic [`SMP_W-1:0] code, output logic clip);
    logic [`SMP_W-1:0] raw;
    int s;
    int prod;
    int q;
    int v;
    // inverted offset binary, msb kept
    raw = pin[`ADC_PIN_W-1:2] ^ {1'b0, {(`SMP_W-1){1'b1}}};
    s = $signed(raw);
    prod = s * g;
    // floor division by the gain scale
    q = prod / (1 << `CAL_SHIFT);
    if ((prod % (1 << `CAL_SHIFT)) != 0 && prod < 0) q = q - 1;
    v = q + o;
    clip = 1'b0;
    if (v > SAT_MAX) begin
      v = SAT_MAX;
      clip = 1'b1;
    end else if (v < SAT_MIN) begin
      v = SAT_MIN;
      clip = 1'b1;
    end
    // sign kept, low bits inverted
    code = v[`SMP_W-1:0] ^ {1'b0, {(`SMP_W-1){1'b1}}};
  endtask

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_base);
    test_base = errors;
  endtask

  // one clock: drive inputs, advance model, check outputs after the edge
  task automatic step(input logic we, input logic [`CAL_AW-1:0] addr,
                      input logic [`CAL_MW-1:0] dat, input logic clr);
    logic [`NUM_CH-1:0][`SMP_W-1:0] codes;
    logic [`NUM_CH-1:0]             clips;
    logic                           c;
    int                             ch;
    cal_we_i   = we;
    cal_addr_i = addr;
    cal_dat_i  = dat;
    clip_clr_i = clr;
    // write is seen by the sample driven in the same cycle
    if (we) begin
      ch = int'(addr[`CAL_AW-2:0]);
      if (addr[`CAL_AW-1]) offs_m[ch] = $signed(dat[`SMP_W-1:0]);
      else gain_m[ch] = $signed(dat);
    end
    for (int i = 0; i < `NUM_CH; i++) begin
      adc_dat_i[i] = 16'(lfsr_bits(`ADC_PIN_W));
      predict_sample(adc_dat_i[i], gain_m[i], offs_m[i], codes[i], c);
      clips[i] = c;
    end
    code_q.push_back(codes);
    clip_q.push_back(clips);
    @(posedge adc_clk);
    #2;
    // 4 deep pipeline
    if (code_q.size() == 4) begin
      codes = code_q.pop_front();
      clips = clip_q.pop_front();
      compare("dac_vld_o", 32'd1, 32'(dac_vld_o));
      compare("dac_dat_o", 32'(codes), 32'(dac_dat_o));
      if (clr) clip_m = '0;
      else clip_m = clip_m | clips;
    end else begin
      compare("dac_vld_o", 32'd0, 32'(dac_vld_o));
      if (clr) clip_m = '0;
    end
    compare("clip_o", 32'(clip_m), 32'(clip_o));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int n;
    top_rst    = 1'b1;
    adc_dat_i  = '0;
    cal_we_i   = 1'b0;
    cal_addr_i = '0;
    cal_dat_i  = '0;
    clip_clr_i = 1'b0;
    clip_m     = '0;
    for (int i = 0; i < `NUM_CH; i++) begin
      gain_m[i] = `CAL_UNITY;
      offs_m[i] = 0;
    end

    // reset, then wait for the stream to come up
    repeat (16) @(posedge adc_clk);
    #2;
    compare("dac_vld_o", 32'd0, 32'(dac_vld_o));
    compare("clip_o", 32'd0, 32'(clip_o));
    top_rst = 1'b0;
    n = 0;
    while (!dac_vld_o && n < 20) begin
      step(1'b0, '0, '0, 1'b0);
      n++;
    end
    if (!dac_vld_o) begin
      errors++;
      $display("timeout: dac_vld_o did not rise after reset release");
    end
    compare("cycles to dac_vld_o", 32'd4, 32'(n));
    end_test("reset");

    // unity gain, zero offset
    repeat (40) step(1'b0, '0, '0, 1'b0);
    end_test("unity");

    // random coefficients per channel
    for (int ch = 0; ch < `NUM_CH; ch++) begin
      step(1'b1, `CAL_AW'(ch), 16'(lfsr_bits(16)), 1'b0);
      step(1'b1, `CAL_AW'(ch + OFFS_SEL), 16'(lfsr_bits(16)), 1'b0);
    end
    repeat (40) step(1'b0, '0, '0, 1'b0);
    end_test("random calibration");

    // saturation both ways, then clear
    step(1'b0, '0, '0, 1'b1);
    step(1'b1, `CAL_AW'(0), 16'h7fff, 1'b0);
    step(1'b1, `CAL_AW'(OFFS_SEL), 16'h1fff, 1'b0);
    step(1'b1, `CAL_AW'(1), 16'h8000, 1'b0);
    step(1'b1, `CAL_AW'(1 + OFFS_SEL), 16'h2000, 1'b0);
    repeat (10) step(1'b0, '0, '0, 1'b0);
    compare("clip_o", 32'h3, 32'(clip_o));
    for (int ch = 0; ch < `NUM_CH; ch++) begin
      step(1'b1, `CAL_AW'(ch), 16'(`CAL_UNITY), 1'b0);
      step(1'b1, `CAL_AW'(ch + OFFS_SEL), 16'h0000, 1'b0);
    end
    // flush clipped samples still in flight
    repeat (4) step(1'b0, '0, '0, 1'b0);
    step(1'b0, '0, '0, 1'b1);
    repeat (10) step(1'b0, '0, '0, 1'b0);
    compare("clip_o", 32'd0, 32'(clip_o));
    end_test("saturation");

    // offset write leaves the gain alone
    step(1'b1, `CAL_AW'(1), 16'(lfsr_bits(14)), 1'b0);
    step(1'b1, `CAL_AW'(1 + OFFS_SEL), 16'(lfsr_bits(16)), 1'b0);
    repeat (20) step(1'b0, '0, '0, 1'b0);
    end_test("offset only");

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule : tb_adc_calib

//--- compile.f
+incdir+rtl
rtl/adc_calib_pkg.sv
rtl/adc_frontend.sv
rtl/calib_regs.sv
rtl/linear_calib.sv
rtl/dac_formatter.sv
rtl/adc_calib_top.sv
bench/tb_adc_calib.sv

//--- Makefile
# Verilator build and run for the acquisition path testbench

VERILATOR ?= verilator
TOP       ?= tb_adc_calib
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
